// File: dma_cfg.svh
/*
 * Widths and memory depths of the DMA write subsystem, shared by the
 * package, the interfaces and the RTL
 */
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

`define DMA_ADDR_W     8
`define DMA_DATA_W     32
`define DMA_LEN_W      8
`define DMA_SRC_DEPTH  64
// Smaller than the address range on purpose
`define DMA_DST_DEPTH  32

`endif

// File: dma_pkg.sv
/*
 * Engine state, AXI burst and response codes and the word types
 */
`include "dma_cfg.svh"

package dma_pkg;

   typedef enum logic [1:0] {
      ADDR_HS    = 2'd0,
      WRITE      = 2'd1,
      W_RESPONSE = 2'd2
   } wr_state_e;

   typedef enum logic [1:0] {
      FIXED = 2'd0,
      INCR  = 2'd1,
      WRAP  = 2'd2
   } axi_burst_e;

   typedef enum logic [1:0] {
      OKAY   = 2'd0,
      EXOKAY = 2'd1,
      SLVERR = 2'd2,
      DECERR = 2'd3
   } axi_resp_e;

   typedef logic [`DMA_DATA_W-1:0] data_t;
   typedef logic [`DMA_ADDR_W-1:0] addr_t;
   typedef logic [`DMA_LEN_W-1:0]  len_t;

endpackage

// File: axi_wr_if.sv
/*
 * AXI-4 write channels (address, data, response) between the burst
 * engine as manager and the sink RAM as subordinate
 */
`include "dma_cfg.svh"

interface axi_wr_if;
   import dma_pkg::*;

   // Write address
   logic       awvalid;
   logic       awready;
   addr_t      awaddr;
   len_t       awlen;
   logic [2:0] awsize;
   axi_burst_e awburst;

   // Write data
   logic                    wvalid;
   logic                    wready;
   data_t                   wdata;
   logic [`DMA_DATA_W/8-1:0] wstrb;
   logic                    wlast;

   // Write response
   logic      bvalid;
   logic      bready;
   axi_resp_e bresp;

   modport mgr (
      output awvalid, awaddr, awlen, awsize, awburst,
      output wvalid, wdata, wstrb, wlast,
      output bready,
      input  awready, wready, bvalid, bresp
   );

   modport sub (
      input  awvalid, awaddr, awlen, awsize, awburst,
      input  wvalid, wdata, wstrb, wlast,
      input  bready,
      output awready, wready, bvalid, bresp
   );

endinterface

// File: iob_rd_if.sv
/*
 * Native valid/ready read port from the burst engine to the source RAM
 */
`include "dma_cfg.svh"

interface iob_rd_if;
   import dma_pkg::*;

   logic                     valid;
   addr_t                    addr;
   data_t                    rdata;
   logic [`DMA_DATA_W/8-1:0] rstrb;
   logic                     ready;

   modport mgr (output valid, addr, input rdata, rstrb, ready);
   modport sub (input valid, addr, output rdata, rstrb, ready);

endinterface

// File: src_mem.sv
/*
 * Source RAM of the DMA: loaded through a plain write port, read by the
 * engine over the native port with a same-cycle answer
 */
`include "dma_cfg.svh"

module src_mem (
   input  logic           clk_i,
   input  logic           ld_we_i,
   input  dma_pkg::addr_t ld_addr_i,
   input  dma_pkg::data_t ld_data_i,
   iob_rd_if.sub          rd
);
   import dma_pkg::*;

   localparam int unsigned IDX_W = $clog2(`DMA_SRC_DEPTH);

   data_t            mem [`DMA_SRC_DEPTH];
   logic [IDX_W-1:0] ld_idx;
   logic [IDX_W-1:0] rd_idx;

   // Depth is a power of two, so dropping the upper bits wraps the address
   assign ld_idx = ld_addr_i[IDX_W-1:0];
   assign rd_idx = rd.addr[IDX_W-1:0];

   // Load port
   always_ff @(posedge clk_i) begin
      if (ld_we_i) begin
         mem[ld_idx] <= ld_data_i;
      end
   end

   // Read side answers in the same cycle
   assign rd.ready = rd.valid;
   assign rd.rdata = mem[rd_idx];
   // Every read returns a full word
   assign rd.rstrb = '1;

endmodule

// File: burst_wr_engine.sv
/*
 * Write DMA engine: fetches words over the native read port and sends
 * them as one AXI incrementing burst, then records the write response
 */
`include "dma_cfg.svh"

module burst_wr_engine (
   input  logic           clk_i,
   input  logic           rst_i,
   input  logic           run_i,
   input  dma_pkg::addr_t src_addr_i,
   input  dma_pkg::addr_t dst_addr_i,
   input  dma_pkg::len_t  length_i,
   output logic           ready_o,
   output logic           error_o,
   iob_rd_if.mgr          rd,
   axi_wr_if.mgr          axi
);
   import dma_pkg::*;

   localparam int unsigned AWSIZE = $clog2(`DMA_DATA_W / 8);

   wr_state_e state_q;
   wr_state_e state_d;

   // One bit wider than the length so that length 255 still counts
   logic [`DMA_LEN_W:0] cnt_q;

   // Command copies
   addr_t src_q;
   addr_t dst_q;
   len_t  len_q;

   logic aw_pend_q;
   logic ready_q;
   logic error_q;

   logic go;
   logic beat;
   logic last_beat;
   logic b_done;

   // A command is taken only while idle
   assign go        = (state_q == ADDR_HS) & ready_q & run_i;
   // The source answers in the same cycle, so a beat needs only wready
   assign beat      = (state_q == WRITE) & axi.wready & rd.ready;
   assign last_beat = (cnt_q == {1'b0, len_q});
   assign b_done    = (state_q == W_RESPONSE) & axi.bvalid;

   // Next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         ADDR_HS: begin
            if (go) begin
               state_d = WRITE;
            end
         end
         WRITE: begin
            if (beat && last_beat) begin
               state_d = W_RESPONSE;
            end
         end
         W_RESPONSE: begin
            if (b_done) begin
               state_d = ADDR_HS;
            end
         end
         default: state_d = ADDR_HS;
      endcase
   end

   // State, beat counter and status
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q   <= ADDR_HS;
         cnt_q     <= '0;
         aw_pend_q <= 1'b0;
         ready_q   <= 1'b1;
         error_q   <= 1'b0;
      end else begin
         state_q <= state_d;

         if (go) begin
            cnt_q <= '0;
         end else if (beat) begin
            cnt_q <= cnt_q + 1'b1;
         end

         // Address stays offered until the sink accepts it
         if (go) begin
            aw_pend_q <= ~axi.awready;
         end else if (aw_pend_q && axi.awready) begin
            aw_pend_q <= 1'b0;
         end

         // Ready comes back one cycle after the return to idle
         if (go) begin
            ready_q <= 1'b0;
         end else if (state_q == ADDR_HS) begin
            ready_q <= 1'b1;
         end

         if (b_done) begin
            error_q <= (axi.bresp != OKAY);
         end
      end
   end

   // Command registers
   always_ff @(posedge clk_i) begin
      if (go) begin
         src_q <= src_addr_i;
         dst_q <= dst_addr_i;
         len_q <= length_i;
      end
   end

   // Write address, straight from the command in the start cycle
   assign axi.awvalid = go | aw_pend_q;
   assign axi.awaddr  = go ? dst_addr_i : dst_q;
   assign axi.awlen   = go ? length_i : len_q;
   assign axi.awsize  = 3'(AWSIZE);
   assign axi.awburst = INCR;

   // Write data comes straight from the source read
   assign axi.wvalid = (state_q == WRITE);
   assign axi.wdata  = rd.rdata;
   assign axi.wstrb  = rd.rstrb;
   assign axi.wlast  = (state_q == WRITE) & last_beat;

   assign axi.bready = (state_q == W_RESPONSE);

   // Source is read only when the sink can take the word
   assign rd.valid = (state_q == WRITE) & axi.wready;
   assign rd.addr  = src_q + addr_t'(cnt_q);

   assign ready_o = ready_q;
   assign error_o = error_q;

endmodule

// File: axi_wr_ram.sv
/*
 * Sink RAM with an AXI-4 write port and range checking; a second,
 * asynchronous read port lets the contents be read back
 */
`include "dma_cfg.svh"

module axi_wr_ram (
   input  logic           clk_i,
   input  logic           rst_i,
   input  logic           hold_i,
   axi_wr_if.sub          axi,
   input  dma_pkg::addr_t dbg_addr_i,
   output dma_pkg::data_t dbg_data_o
);
   import dma_pkg::*;

   localparam int unsigned IDX_W     = $clog2(`DMA_DST_DEPTH);
   localparam int unsigned NBYTES    = `DMA_DATA_W / 8;
   localparam int unsigned FULL_SIZE = $clog2(`DMA_DATA_W / 8);

   data_t     mem [`DMA_DST_DEPTH];
   wr_state_e state_q;
   addr_t     addr_q;
   len_t      len_q;
   len_t      cnt_q;
   logic      err_q;

   logic aw_hs;
   logic w_hs;
   logic b_hs;
   logic in_range;
   logic len_bad;

   assign aw_hs = axi.awvalid & axi.awready;
   assign w_hs  = axi.wvalid & axi.wready;
   assign b_hs  = axi.bvalid & axi.bready;

   assign in_range = (addr_q < addr_t'(`DMA_DST_DEPTH));
   // wlast has to agree with the length given on the address channel
   assign len_bad  = axi.wlast != (cnt_q == len_q);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= ADDR_HS;
         cnt_q   <= '0;
         err_q   <= 1'b0;
      end else begin
         case (state_q)
            ADDR_HS: begin
               if (aw_hs) begin
                  state_q <= WRITE;
                  cnt_q   <= '0;
                  // Only full-width incrementing bursts
                  err_q   <= (axi.awburst != INCR) | (axi.awsize != 3'(FULL_SIZE));
               end
            end
            WRITE: begin
               if (w_hs) begin
                  cnt_q <= cnt_q + 1'b1;
                  if (!in_range || len_bad) begin
                     err_q <= 1'b1;
                  end
                  if (axi.wlast) begin
                     state_q <= W_RESPONSE;
                  end
               end
            end
            W_RESPONSE: begin
               if (b_hs) begin
                  state_q <= ADDR_HS;
               end
            end
            default: state_q <= ADDR_HS;
         endcase
      end
   end

   // Burst address, one word per beat
   always_ff @(posedge clk_i) begin
      if (aw_hs) begin
         addr_q <= axi.awaddr;
         len_q  <= axi.awlen;
      end else if (w_hs) begin
         addr_q <= addr_q + 1'b1;
      end
   end

   // Out-of-range beats are dropped
   always_ff @(posedge clk_i) begin
      if (w_hs && in_range) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (axi.wstrb[b]) begin
               mem[addr_q[IDX_W-1:0]][8*b +: 8] <= axi.wdata[8*b +: 8];
            end
         end
      end
   end

   assign axi.awready = (state_q == ADDR_HS);
   assign axi.wready  = (state_q == WRITE) & ~hold_i;
   assign axi.bvalid  = (state_q == W_RESPONSE);
   assign axi.bresp   = err_q ? SLVERR : OKAY;

   // Read-back port, zero outside the array
   assign dbg_data_o = (dbg_addr_i < addr_t'(`DMA_DST_DEPTH)) ?
                       mem[dbg_addr_i[IDX_W-1:0]] : '0;

endmodule

// File: dma_wr_top.sv
/*
 * DMA write subsystem top: source RAM, burst engine and AXI sink RAM
 * joined by the native read and AXI write interfaces
 */
module dma_wr_top (
   input  logic           clk_i,
   input  logic           rst_i,

   // Source load port
   input  logic           ld_we_i,
   input  dma_pkg::addr_t ld_addr_i,
   input  dma_pkg::data_t ld_data_i,

   // Command and status
   input  logic           run_i,
   input  dma_pkg::addr_t src_addr_i,
   input  dma_pkg::addr_t dst_addr_i,
   input  dma_pkg::len_t  length_i,
   output logic           ready_o,
   output logic           error_o,

   // Sink back-pressure and read-back
   input  logic           sink_hold_i,
   input  dma_pkg::addr_t dbg_addr_i,
   output dma_pkg::data_t dbg_data_o
);

   axi_wr_if axi_if_inst ();
   iob_rd_if rd_if_inst ();

   src_mem src_mem_inst (
      .clk_i     (clk_i),
      .ld_we_i   (ld_we_i),
      .ld_addr_i (ld_addr_i),
      .ld_data_i (ld_data_i),
      .rd        (rd_if_inst.sub)
   );

   burst_wr_engine burst_wr_engine_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .run_i      (run_i),
      .src_addr_i (src_addr_i),
      .dst_addr_i (dst_addr_i),
      .length_i   (length_i),
      .ready_o    (ready_o),
      .error_o    (error_o),
      .rd         (rd_if_inst.mgr),
      .axi        (axi_if_inst.mgr)
   );

   axi_wr_ram axi_wr_ram_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .hold_i     (sink_hold_i),
      .axi        (axi_if_inst.sub),
      .dbg_addr_i (dbg_addr_i),
      .dbg_data_o (dbg_data_o)
   );

endmodule

// File: dma_wr_props.sv
/*
 * Concurrent checks on the AXI write channels of the burst engine,
 * attached to every engine instance by bind
 */
`include "dma_cfg.svh"

module dma_wr_props (
   input logic                clk_i,
   input logic                rst_i,
   input logic                ready_i,
   input logic                awvalid_i,
   input logic                awready_i,
   input dma_pkg::len_t       awlen_i,
   input logic                wvalid_i,
   input logic                wready_i,
   input logic                wlast_i,
   input logic                bready_i
);
   import dma_pkg::*;

   logic [`DMA_LEN_W:0] beat_q;
   len_t                len_q;

   // Beats seen since the address handshake
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         beat_q <= '0;
         len_q  <= '0;
      end else if (awvalid_i && awready_i) begin
         beat_q <= '0;
         len_q  <= awlen_i;
      end else if (wvalid_i && wready_i) begin
         beat_q <= beat_q + 1'b1;
      end
   end

   aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      awvalid_i && !awready_i |=> awvalid_i)
      else $error("awvalid dropped before its handshake");

   w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      wvalid_i && !wready_i |=> wvalid_i)
      else $error("wvalid dropped before its handshake");

   wlast_pos: assert property (@(posedge clk_i) disable iff (rst_i)
      wvalid_i && wready_i |-> (wlast_i == (beat_q == {1'b0, len_q})))
      else $error("wlast not on the last beat of the burst");

   busy_low: assert property (@(posedge clk_i) disable iff (rst_i)
      (wvalid_i || bready_i) |-> !ready_i)
      else $error("ready_o high while a burst is in flight");

endmodule

bind burst_wr_engine dma_wr_props dma_wr_props_inst (
   .clk_i     (clk_i),
   .rst_i     (rst_i),
   .ready_i   (ready_o),
   .awvalid_i (axi.awvalid),
   .awready_i (axi.awready),
   .awlen_i   (axi.awlen),
   .wvalid_i  (axi.wvalid),
   .wready_i  (axi.wready),
   .wlast_i   (axi.wlast),
   .bready_i  (axi.bready)
);

// File: dma_wr_tb.sv
/*
 * Testbench of the DMA write subsystem: loads the source RAM, runs a table
 * of bursts and compares status and sink contents with a reference model
 */
`include "dma_cfg.svh"

module dma_wr_tb;
   import dma_pkg::*;

   localparam int NROWS   = 8;
   localparam int TIMEOUT = 2000;

   // One burst of the table with its expected response
   typedef struct packed {
      addr_t       src;
      addr_t       dst;
      len_t        len;
      logic [31:0] hold;
      logic        err;
   } burst_row_t;

   logic  clk_i;
   logic  rst_i;
   logic  ld_we_i;
   addr_t ld_addr_i;
   data_t ld_data_i;
   logic  run_i;
   addr_t src_addr_i;
   addr_t dst_addr_i;
   len_t  length_i;
   logic  ready_o;
   logic  error_o;
   logic  sink_hold_i;
   addr_t dbg_addr_i;
   data_t dbg_data_o;

   burst_row_t tbl [NROWS];
   data_t      src_model [`DMA_SRC_DEPTH];
   data_t      dst_model [`DMA_DST_DEPTH];
   logic       dst_written [`DMA_DST_DEPTH];

   dma_wr_top dma_wr_top_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ld_we_i     (ld_we_i),
      .ld_addr_i   (ld_addr_i),
      .ld_data_i   (ld_data_i),
      .run_i       (run_i),
      .src_addr_i  (src_addr_i),
      .dst_addr_i  (dst_addr_i),
      .length_i    (length_i),
      .ready_o     (ready_o),
      .error_o     (error_o),
      .sink_hold_i (sink_hold_i),
      .dbg_addr_i  (dbg_addr_i),
      .dbg_data_o  (dbg_data_o)
   );

   always #2 clk_i = ~clk_i;

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("TESTS FAILED");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         report_failure($sformatf("error: time %0t %s got %h expected %h",
                                  $time, name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("error: time %0t %s got %b expected %b",
                                  $time, name, got, exp));
      end
   endtask

   // Mostly low, so a burst always makes progress
   function automatic logic [31:0] random_hold_pattern();
      return $urandom() & 32'h6db6_db6d;
   endfunction

   task automatic init_table();
      tbl[0] = '{8'd5,  8'd3,   8'd0,  32'h0, 1'b0};
      tbl[1] = '{8'd8,  8'd10,  8'd15, 32'h0, 1'b0};
      // Fills the whole sink
      tbl[2] = '{8'd32, 8'd0,   8'd31, random_hold_pattern(), 1'b0};
      // Source address wraps past the end of the RAM
      tbl[3] = '{8'd60, 8'd7,   8'd9,  random_hold_pattern(), 1'b0};
      // Crosses the end of the sink
      tbl[4] = '{8'd0,  8'd28,  8'd7,  random_hold_pattern(), 1'b1};
      tbl[5] = '{8'd20, 8'd12,  8'd3,  32'h0, 1'b0};
      tbl[6] = '{8'd44, 8'd200, 8'd2,  32'h0, 1'b1};
      tbl[7] = '{8'd50, 8'd31,  8'd0,  random_hold_pattern(), 1'b0};
   endtask

   task automatic load_source();
      data_t v;
      for (int i = 0; i < `DMA_SRC_DEPTH; i++) begin
         v = $urandom();
         src_model[i] = v;
         @(posedge clk_i);
         ld_we_i   <= 1'b1;
         ld_addr_i <= addr_t'(i);
         ld_data_i <= v;
      end
      @(posedge clk_i);
      ld_we_i <= 1'b0;
   endtask

   // Sink model: in-range beats land at dst+i, the rest are dropped
   function automatic void update_model(input burst_row_t row);
      addr_t a;
      int    idx;
      for (int i = 0; i <= int'(row.len); i++) begin
         a   = row.dst + addr_t'(i);
         idx = int'(a);
         if (idx < `DMA_DST_DEPTH) begin
            dst_model[idx]   = src_model[int'(row.src + addr_t'(i)) % `DMA_SRC_DEPTH];
            dst_written[idx] = 1'b1;
         end
      end
   endfunction

   // Drives the hold pattern each cycle while it waits
   task automatic wait_ready(input logic [31:0] hold, input string what);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < TIMEOUT) begin
         @(posedge clk_i);
         sink_hold_i <= hold[n % 32];
         @(negedge clk_i);
         seen = ready_o;
         n++;
      end
      if (!seen) begin
         report_failure($sformatf("timeout: ready_o did not rise %s", what));
      end
   endtask

   task automatic read_back();
      for (int a = 0; a < `DMA_DST_DEPTH; a++) begin
         @(posedge clk_i);
         dbg_addr_i <= addr_t'(a);
         @(negedge clk_i);
         if (dst_written[a]) begin
            check_data($sformatf("dbg_data_o[%0d]", a), dbg_data_o, dst_model[a]);
         end
      end
   endtask

   task automatic run_row(input burst_row_t row);
      wait_ready(32'h0, "before the run pulse");
      @(posedge clk_i);
      run_i      <= 1'b1;
      src_addr_i <= row.src;
      dst_addr_i <= row.dst;
      length_i   <= row.len;
      @(posedge clk_i);
      run_i <= 1'b0;
      @(negedge clk_i);
      check_flag("ready_o", ready_o, 1'b0);
      update_model(row);
      wait_ready(row.hold, "at the end of a burst");
      check_flag("error_o", error_o, row.err);
      read_back();
   endtask

   initial begin
      void'($urandom(18));
      clk_i       = 1'b0;
      rst_i       = 1'b1;
      ld_we_i     = 1'b0;
      ld_addr_i   = '0;
      ld_data_i   = '0;
      run_i       = 1'b0;
      src_addr_i  = '0;
      dst_addr_i  = '0;
      length_i    = '0;
      sink_hold_i = 1'b0;
      dbg_addr_i  = '0;
      for (int i = 0; i < `DMA_DST_DEPTH; i++) begin
         dst_written[i] = 1'b0;
      end
      init_table();

      repeat (16) @(posedge clk_i);
      rst_i <= 1'b0;
      @(negedge clk_i);
      check_flag("ready_o", ready_o, 1'b1);
      check_flag("error_o", error_o, 1'b0);

      load_source();
      for (int r = 0; r < NROWS; r++) begin
         run_row(tbl[r]);
      end

      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: sources.f
+incdir+.
dma_pkg.sv
axi_wr_if.sv
iob_rd_if.sv
src_mem.sv
burst_wr_engine.sv
axi_wr_ram.sv
dma_wr_top.sv
dma_wr_props.sv
dma_wr_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := dma_wr_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS      := TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
